/* fp_pkg.sv */
// --------------------------------------------------
// Single-precision word layout, canonical NaN and
// fclass bit positions for the rvfpm coprocessor
// --------------------------------------------------
`default_nettype none

package fp_pkg;

  // FP word width and its fields
  localparam int unsigned flen  = 32;
  localparam int unsigned exp_w = 8;
  localparam int unsigned man_w = 23;

  // IEEE 754 binary32 split into its fields
  typedef struct packed {
    logic             sign;
    logic [exp_w-1:0] exponent;
    logic [man_w-1:0] mantissa;
  } fp_word_t;

  // Quiet NaN returned when min/max sees two NaNs
  localparam fp_word_t canonical_nan = 32'h7fc0_0000;

  // --------------------------------------------------
  // fclass mask, one bit per class
  // --------------------------------------------------
  localparam int unsigned cls_w            = 10;
  localparam int unsigned cls_neg_inf      = 0;
  localparam int unsigned cls_neg_normal   = 1;
  localparam int unsigned cls_neg_subnorm  = 2;
  localparam int unsigned cls_neg_zero     = 3;
  localparam int unsigned cls_pos_zero     = 4;
  localparam int unsigned cls_pos_subnorm  = 5;
  localparam int unsigned cls_pos_normal   = 6;
  localparam int unsigned cls_pos_inf      = 7;
  localparam int unsigned cls_snan         = 8;
  localparam int unsigned cls_qnan         = 9;

endpackage

`default_nettype wire

/* xif_pkg.sv */
// --------------------------------------------------
// Coprocessor interface types: opcodes and the
// packed issue and result words
// --------------------------------------------------
`default_nettype none

package xif_pkg;

  // Instruction tag width
  localparam int unsigned id_w = 4;

  // Integer operand width, as on the core side
  localparam int unsigned xlen = 32;

  // Register index as in the instruction encoding
  typedef logic [4:0] reg_idx_t;

  // --------------------------------------------------
  // Supported F-extension operations
  // --------------------------------------------------
  typedef enum logic [3:0] {
    // Sign injection
    op_fsgnj,
    op_fsgnjn,
    op_fsgnjx,
    // Min and max
    op_fmin,
    op_fmax,
    // Quiet compares, integer result
    op_feq,
    op_flt,
    op_fle,
    // Classify, integer result
    op_fclass,
    // Bit moves between register files
    op_fmv_w_x,
    op_fmv_x_w
  } fp_op_e;

  // --------------------------------------------------
  // Issue word, held stable while issue_req is high
  // --------------------------------------------------
  typedef struct packed {
    fp_op_e          op;
    logic [id_w-1:0] id;
    reg_idx_t        rd;
    reg_idx_t        rs1;
    reg_idx_t        rs2;
    // Source for fmv.w.x only
    logic [xlen-1:0] int_operand;
  } issue_t;

  // Result word, held stable while result_req is high
  typedef struct packed {
    logic [id_w-1:0]          id;
    reg_idx_t                 rd;
    // Set when data went to the FP register file
    logic                     fp_write;
    logic [fp_pkg::flen-1:0]  data;
  } result_t;

endpackage

`default_nettype wire

/* fp_regfile.sv */
// --------------------------------------------------
// FP register file, two combinational read ports
// and one clocked write port
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fp_regfile #(
  parameter int unsigned num_f_regs = 32
) (
  input  wire                uin_rvfpm,
  input  wire                arst_n,
  // Read ports
  input  xif_pkg::reg_idx_t  rs1,
  input  xif_pkg::reg_idx_t  rs2,
  output fp_pkg::fp_word_t   rs1_value,
  output fp_pkg::fp_word_t   rs2_value,
  // Write port
  input  wire                we,
  input  xif_pkg::reg_idx_t  waddr,
  input  fp_pkg::fp_word_t   wdata
);

  import fp_pkg::*;

  // Only the low index bits select a register
  localparam int unsigned idx_w = $clog2(num_f_regs);

  fp_word_t regs [num_f_regs];

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------
  always_ff @(posedge uin_rvfpm or negedge arst_n) begin
    if (!arst_n) begin
      // All registers start at zero
      for (int i = 0; i < num_f_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr[idx_w-1:0]] <= wdata;
    end
  end

  // --------------------------------------------------
  // Read ports
  // --------------------------------------------------
  // Combinational, same cycle as the index
  assign rs1_value = regs[rs1[idx_w-1:0]];
  assign rs2_value = regs[rs2[idx_w-1:0]];

endmodule

`default_nettype wire

/* fp_exec_unit.sv */
// --------------------------------------------------
// Execute unit: operand register and the sign-inject,
// min/max, compare, classify and move datapath
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fp_exec_unit (
  input  wire               uin_rvfpm,
  input  wire               arst_n,
  input  wire               capture,
  input  xif_pkg::issue_t   issue,
  input  fp_pkg::fp_word_t  rs1_value,
  input  fp_pkg::fp_word_t  rs2_value,
  output xif_pkg::result_t  result,
  output logic              fp_write
);

  import fp_pkg::*;
  import xif_pkg::*;

  // Captured instruction and operands
  fp_op_e          op_q;
  logic [id_w-1:0] id_q;
  reg_idx_t        rd_q;
  fp_word_t        a_q;
  fp_word_t        b_q;

  // Operand properties
  logic a_nan;
  logic b_nan;
  logic any_nan;
  logic a_zero;
  logic both_zero;
  logic a_inf;
  logic a_subnorm;
  logic a_normal;

  // Comparison results
  logic a_lt_b;
  logic a_below_b;
  logic feq_r;
  logic flt_r;
  logic fle_r;

  fp_word_t         minmax_r;
  logic [cls_w-1:0] class_mask;
  logic [flen-1:0]  data_r;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic is_nan(input fp_word_t x);
    return (x.exponent == '1) && (x.mantissa != '0);
  endfunction

  function automatic logic is_zero(input fp_word_t x);
    return (x.exponent == '0) && (x.mantissa != '0) == 1'b0;
  endfunction

  // Ordered less-than, both zeros compare equal
  function automatic logic fp_lt(input fp_word_t x, input fp_word_t y);
    logic lt;
    if (is_zero(x) && is_zero(y)) begin
      lt = 1'b0;
    end else if (x.sign != y.sign) begin
      // Negative side is smaller
      lt = x.sign;
    end else if (x.sign) begin
      // Both negative, larger magnitude is smaller
      lt = {x.exponent, x.mantissa} > {y.exponent, y.mantissa};
    end else begin
      lt = {x.exponent, x.mantissa} < {y.exponent, y.mantissa};
    end
    return lt;
  endfunction

  // --------------------------------------------------
  // Capture register
  // --------------------------------------------------
  always_ff @(posedge uin_rvfpm or negedge arst_n) begin
    if (!arst_n) begin
      op_q <= op_fsgnj;
      id_q <= '0;
      rd_q <= '0;
      a_q  <= '0;
      b_q  <= '0;
    end else if (capture) begin
      op_q <= issue.op;
      id_q <= issue.id;
      rd_q <= issue.rd;
      // fmv.w.x takes its bits from the integer side
      a_q  <= (issue.op == op_fmv_w_x) ? fp_word_t'(issue.int_operand) : rs1_value;
      b_q  <= rs2_value;
    end
  end

  // --------------------------------------------------
  // Operand decode and compares
  // --------------------------------------------------
  assign a_nan     = is_nan(a_q);
  assign b_nan     = is_nan(b_q);
  assign any_nan   = a_nan | b_nan;
  assign a_zero    = is_zero(a_q);
  assign both_zero = a_zero & is_zero(b_q);
  assign a_inf     = (a_q.exponent == '1) && (a_q.mantissa == '0);
  assign a_subnorm = (a_q.exponent == '0) && (a_q.mantissa != '0);
  assign a_normal  = (a_q.exponent != '0) && (a_q.exponent != '1);

  assign a_lt_b    = fp_lt(a_q, b_q);
  // For min/max -0 sits below +0
  assign a_below_b = both_zero ? (a_q.sign & ~b_q.sign) : a_lt_b;

  // Quiet compares, any NaN gives 0
  assign feq_r = ~any_nan & (both_zero | (a_q == b_q));
  assign flt_r = ~any_nan & a_lt_b;
  assign fle_r = flt_r | feq_r;

  // Min/max with NaN propagation rules
  always_comb begin
    if (a_nan && b_nan) begin
      minmax_r = canonical_nan;
    end else if (a_nan) begin
      minmax_r = b_q;
    end else if (b_nan) begin
      minmax_r = a_q;
    end else if (op_q == op_fmin) begin
      minmax_r = a_below_b ? a_q : b_q;
    end else begin
      minmax_r = a_below_b ? b_q : a_q;
    end
  end

  // One-hot class of rs1
  always_comb begin
    class_mask                  = '0;
    class_mask[cls_neg_inf]     = a_q.sign & a_inf;
    class_mask[cls_neg_normal]  = a_q.sign & a_normal;
    class_mask[cls_neg_subnorm] = a_q.sign & a_subnorm;
    class_mask[cls_neg_zero]    = a_q.sign & a_zero;
    class_mask[cls_pos_zero]    = ~a_q.sign & a_zero;
    class_mask[cls_pos_subnorm] = ~a_q.sign & a_subnorm;
    class_mask[cls_pos_normal]  = ~a_q.sign & a_normal;
    class_mask[cls_pos_inf]     = ~a_q.sign & a_inf;
    // Quiet bit is the mantissa MSB
    class_mask[cls_snan]        = a_nan & ~a_q.mantissa[man_w-1];
    class_mask[cls_qnan]        = a_nan & a_q.mantissa[man_w-1];
  end

  // --------------------------------------------------
  // Result select
  // --------------------------------------------------
  always_comb begin
    case (op_q)
      op_fsgnj:   data_r = {b_q.sign, a_q.exponent, a_q.mantissa};
      op_fsgnjn:  data_r = {~b_q.sign, a_q.exponent, a_q.mantissa};
      op_fsgnjx:  data_r = {a_q.sign ^ b_q.sign, a_q.exponent, a_q.mantissa};
      op_fmin,
      op_fmax:    data_r = minmax_r;
      op_feq:     data_r = {{(flen-1){1'b0}}, feq_r};
      op_flt:     data_r = {{(flen-1){1'b0}}, flt_r};
      op_fle:     data_r = {{(flen-1){1'b0}}, fle_r};
      op_fclass:  data_r = {{(flen-cls_w){1'b0}}, class_mask};
      // Moves copy the bits unchanged
      op_fmv_w_x,
      op_fmv_x_w: data_r = a_q;
      default:    data_r = '0;
    endcase
  end

  // FP destination for sign injection, min/max and fmv.w.x
  assign fp_write = op_q inside {op_fsgnj, op_fsgnjn, op_fsgnjx,
                                 op_fmin, op_fmax, op_fmv_w_x};

  assign result = '{id: id_q, rd: rd_q, fp_write: fp_write, data: data_r};

endmodule

`default_nettype wire

/* exec_timer.sv */
// --------------------------------------------------
// Latency counter standing in for the execute
// pipeline, pulses done after pipeline_stages cycles
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module exec_timer #(
  parameter int unsigned pipeline_stages = 3
) (
  input  wire  uin_rvfpm,
  input  wire  arst_n,
  input  wire  start,
  output logic done
);

  // Wide enough to hold pipeline_stages itself
  localparam int unsigned cnt_w = $clog2(pipeline_stages + 1);

  logic [cnt_w-1:0] count_q;

  // Load on start, count down to zero and stop
  always_ff @(posedge uin_rvfpm or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= '0;
    end else if (start) begin
      count_q <= cnt_w'(pipeline_stages);
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // High for the one cycle in which the count steps to zero
  assign done = (count_q == cnt_w'(1));

endmodule

`default_nettype wire

/* issue_ctrl.sv */
// --------------------------------------------------
// Handshake controller for the four-phase issue and
// result channels, steers timer, capture and write
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module issue_ctrl (
  input  wire  uin_rvfpm,
  input  wire  arst_n,
  // Issue channel
  input  wire  issue_req,
  output logic issue_ack,
  // Result channel
  input  wire  result_ack,
  output logic result_req,
  // Internal control
  input  wire  timer_done,
  input  wire  fp_write,
  output logic capture,
  output logic timer_start,
  output logic rf_we
);

  // Main sequence, issue_ack runs beside it
  typedef enum logic [2:0] {
    idle,
    wait_req_low,
    execute,
    respond,
    wait_ack_low
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   issue_ack_d;

  // --------------------------------------------------
  // Issue side
  // --------------------------------------------------
  // Take the instruction only from idle
  assign capture     = (state_q == idle) && issue_req;
  assign timer_start = capture;

  // Raise on capture, drop once the core releases req
  always_comb begin
    issue_ack_d = issue_ack;
    if (capture) begin
      issue_ack_d = 1'b1;
    end else if (issue_ack && !issue_req) begin
      issue_ack_d = 1'b0;
    end
  end

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (capture) begin
          state_d = execute;
        end
      end
      execute: begin
        if (timer_done) begin
          state_d = respond;
        end
      end
      respond: begin
        if (result_ack) begin
          state_d = wait_ack_low;
        end
      end
      wait_ack_low: begin
        // Issue handshake may still be open
        if (!result_ack) begin
          state_d = issue_ack_d ? wait_req_low : idle;
        end
      end
      wait_req_low: begin
        if (!issue_ack_d) begin
          state_d = idle;
        end
      end
      default: state_d = idle;
    endcase
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  always_ff @(posedge uin_rvfpm or negedge arst_n) begin
    if (!arst_n) begin
      state_q    <= idle;
      issue_ack  <= 1'b0;
      result_req <= 1'b0;
      rf_we      <= 1'b0;
    end else begin
      state_q    <= state_d;
      issue_ack  <= issue_ack_d;
      // High for the whole respond state
      result_req <= (state_d == respond);
      // Single write pulse, FP destinations only
      rf_we      <= (state_q == execute) && timer_done && fp_write;
    end
  end

endmodule

`default_nettype wire

/* rvfpm.sv */
// --------------------------------------------------
// rvfpm top: FP coprocessor with issue/result
// handshakes, execute unit and FP register file
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rvfpm #(
  parameter int unsigned num_f_regs      = 32,
  parameter int unsigned pipeline_stages = 3
) (
  input  wire               uin_rvfpm,
  input  wire               arst_n,
  // Issue channel
  input  wire               issue_req,
  output logic              issue_ack,
  input  xif_pkg::issue_t   issue,
  // Result channel
  output logic              result_req,
  input  wire               result_ack,
  output xif_pkg::result_t  result
);

  import fp_pkg::*;

  // --------------------------------------------------
  // Internal wiring
  // --------------------------------------------------
  logic     capture;
  logic     timer_start;
  logic     timer_done;
  logic     rf_we;
  logic     fp_write;
  // Register file read data into the execute unit
  fp_word_t rs1_value;
  fp_word_t rs2_value;

  // Handshake control
  issue_ctrl i_issue_ctrl (
    .uin_rvfpm   (uin_rvfpm),
    .arst_n      (arst_n),
    .issue_req   (issue_req),
    .issue_ack   (issue_ack),
    .result_ack  (result_ack),
    .result_req  (result_req),
    .timer_done  (timer_done),
    .fp_write    (fp_write),
    .capture     (capture),
    .timer_start (timer_start),
    .rf_we       (rf_we)
  );

  // Execute latency model
  exec_timer #(
    .pipeline_stages (pipeline_stages)
  ) i_exec_timer (
    .uin_rvfpm (uin_rvfpm),
    .arst_n    (arst_n),
    .start     (timer_start),
    .done      (timer_done)
  );

  // Datapath, result held until next capture
  fp_exec_unit i_fp_exec_unit (
    .uin_rvfpm (uin_rvfpm),
    .arst_n    (arst_n),
    .capture   (capture),
    .issue     (issue),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .result    (result),
    .fp_write  (fp_write)
  );

  // Reads from the issue word, writes from the result
  fp_regfile #(
    .num_f_regs (num_f_regs)
  ) i_fp_regfile (
    .uin_rvfpm (uin_rvfpm),
    .arst_n    (arst_n),
    .rs1       (issue.rs1),
    .rs2       (issue.rs2),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .we        (rf_we),
    .waddr     (result.rd),
    .wdata     (result.data)
  );

endmodule

`default_nettype wire

/* rvfpm_assert.sv */
// --------------------------------------------------
// Protocol checks on the issue and result channels
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rvfpm_assert (
  input wire              uin_rvfpm,
  input wire              arst_n,
  input wire              issue_req,
  input wire              issue_ack,
  input wire              result_req,
  input wire              result_ack,
  input xif_pkg::result_t result
);

  // --------------------------------------------------
  // Issue channel
  // --------------------------------------------------
  // Ack answers a request seen at the previous edge
  ack_after_req: assert property (
    @(posedge uin_rvfpm) disable iff (!arst_n)
      $rose(issue_ack) |-> $past(issue_req)
  ) else $error("issue_ack rose without a pending issue_req");

  // --------------------------------------------------
  // Result channel
  // --------------------------------------------------
  // No early withdrawal of result_req
  req_held: assert property (
    @(posedge uin_rvfpm) disable iff (!arst_n)
      (result_req && !result_ack) |=> result_req
  ) else $error("result_req dropped before result_ack");

  // Result word frozen for the whole request
  result_stable: assert property (
    @(posedge uin_rvfpm) disable iff (!arst_n)
      (result_req && $past(result_req)) |-> $stable(result)
  ) else $error("result changed while result_req was high");

endmodule

`default_nettype wire

/* rvfpm_tb.sv */
// --------------------------------------------------
// Directed testbench for the rvfpm coprocessor
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rvfpm_tb;

  import xif_pkg::*;

  localparam int unsigned num_f_regs      = 32;
  localparam int unsigned pipeline_stages = 3;

  // Instructions per test case
  localparam int unsigned n_moves    = 8;
  localparam int unsigned n_sgnj     = 12;
  localparam int unsigned n_mm       = 7;
  localparam int unsigned n_cmp      = 6;
  localparam int unsigned n_cls      = 10;
  localparam int unsigned n_instr    = 1 + 2 * n_moves + n_sgnj + 4 * n_mm
                                       + 5 * n_cmp + 2 * n_cls;
  // Worst case per instruction plus slack for reset
  localparam int unsigned max_cycles = n_instr * (pipeline_stages + 12) + 100;

  logic        uin_rvfpm;
  logic        arst_n;
  logic        issue_req;
  logic        issue_ack;
  issue_t      issue;
  logic        result_req;
  logic        result_ack;
  result_t     result;

  // Model of the FP register file
  logic [31:0] shadow [32];
  logic [3:0]  next_id;
  int unsigned cycle_count;
  // Rising edges seen on each channel
  int unsigned ack_rises;
  int unsigned req_rises;
  logic        issue_ack_q;
  logic        result_req_q;
  logic        ended;

  rvfpm #(
    .num_f_regs      (num_f_regs),
    .pipeline_stages (pipeline_stages)
  ) i_rvfpm (
    .uin_rvfpm  (uin_rvfpm),
    .arst_n     (arst_n),
    .issue_req  (issue_req),
    .issue_ack  (issue_ack),
    .issue      (issue),
    .result_req (result_req),
    .result_ack (result_ack),
    .result     (result)
  );

  bind rvfpm rvfpm_assert i_rvfpm_assert (.*);

  initial begin
    uin_rvfpm = 1'b0;
    forever #2 uin_rvfpm = ~uin_rvfpm;
  end

  // --------------------------------------------------
  // Error handling and monitors
  // --------------------------------------------------
  task automatic fail_run(input string msg);
    ended = 1'b1;
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else fail_run($sformatf("Fail at %0t ns: %s = 0x%h, expected 0x%h",
                              $time, name, got, exp));
  endtask

  // Watchdog
  always @(posedge uin_rvfpm) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      fail_run($sformatf("Timeout after %0d cycles, DUT stopped answering", cycle_count));
    end
  end

  // Each result_req rise needs an earlier issue_ack rise
  always @(negedge uin_rvfpm) begin
    if (arst_n) begin
      if (issue_ack && !issue_ack_q) begin
        ack_rises++;
      end
      if (result_req && !result_req_q) begin
        req_rises++;
        assert (req_rises == ack_rises)
          else fail_run("result_req rose before issue_ack of its instruction");
      end
    end
    issue_ack_q  = issue_ack;
    result_req_q = result_req;
  end

  // --------------------------------------------------
  // Reference rules
  // --------------------------------------------------
  function automatic logic is_nan_word(input logic [31:0] w);
    return (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
  endfunction

  // Unsigned key that sorts like the real value and puts -0 below +0
  function automatic logic [31:0] order_key(input logic [31:0] w);
    return w[31] ? ~w : (w | 32'h8000_0000);
  endfunction

  function automatic logic [31:0] expect_sgnj(input fp_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
    logic s;
    case (op)
      op_fsgnj:  s = b[31];
      op_fsgnjn: s = ~b[31];
      default:   s = a[31] ^ b[31];
    endcase
    return {s, a[30:0]};
  endfunction

  function automatic logic [31:0] expect_minmax(input logic is_max, input logic [31:0] a,
                                                input logic [31:0] b);
    logic na;
    logic nb;
    na = is_nan_word(a);
    nb = is_nan_word(b);
    return (na && nb) ? 32'h7fc0_0000 :
           na ? b :
           nb ? a :
           ((order_key(a) < order_key(b)) != is_max) ? a : b;
  endfunction

  function automatic logic [31:0] expect_cmp(input fp_op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
    logic nan;
    logic zeros;
    logic eq;
    logic lt;
    nan   = is_nan_word(a) || is_nan_word(b);
    // Both zeros compare equal whatever their signs
    zeros = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
    eq    = zeros || (a == b);
    lt    = !zeros && (order_key(a) < order_key(b));
    case (op)
      op_feq:  return {31'd0, !nan && eq};
      op_flt:  return {31'd0, !nan && lt};
      default: return {31'd0, !nan && (lt || eq)};
    endcase
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'($urandom_range(num_f_regs - 1, 0));
  endfunction

  // --------------------------------------------------
  // Channel drivers
  // --------------------------------------------------
  task automatic send_instr(input fp_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [31:0] int_op);
    @(negedge uin_rvfpm);
    issue.op          = op;
    issue.id          = next_id;
    issue.rd          = rd;
    issue.rs1         = rs1;
    issue.rs2         = rs2;
    issue.int_operand = int_op;
    issue_req         = 1'b1;
    while (!issue_ack) @(negedge uin_rvfpm);
    issue_req = 1'b0;
    // Four-phase rule needs the ack to drop first
    while (issue_ack) @(negedge uin_rvfpm);
  endtask

  task automatic take_result(output result_t res);
    int unsigned delay;
    while (!result_req) @(negedge uin_rvfpm);
    res   = result;
    delay = $urandom_range(3, 0);
    // Slow core side
    repeat (delay) @(negedge uin_rvfpm);
    result_ack = 1'b1;
    while (result_req) @(negedge uin_rvfpm);
    result_ack = 1'b0;
  endtask

  // One instruction end to end with all result fields checked
  task automatic exec_check(input fp_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [31:0] int_op,
                            input logic [31:0] exp_data);
    result_t res;
    logic    exp_fp;
    exp_fp = op inside {op_fsgnj, op_fsgnjn, op_fsgnjx, op_fmin, op_fmax, op_fmv_w_x};
    send_instr(op, rd, rs1, rs2, int_op);
    take_result(res);
    check_value("result.id", 32'(res.id), 32'(next_id));
    check_value("result.rd", 32'(res.rd), 32'(rd));
    check_value("result.fp_write", 32'(res.fp_write), 32'(exp_fp));
    check_value("result.data", res.data, exp_data);
    if (exp_fp) begin
      shadow[rd] = exp_data;
    end
    next_id = next_id + 4'd1;
  endtask

  task automatic load_reg(input logic [4:0] idx, input logic [31:0] val);
    exec_check(op_fmv_w_x, idx, 5'd0, 5'd0, val, val);
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic reset_and_order();
    check_value("issue_ack", 32'(issue_ack), 32'd0);
    check_value("result_req", 32'(result_req), 32'd0);
    // Register file comes out of reset at zero
    exec_check(op_fmv_x_w, 5'd1, 5'd5, 5'd0, 32'd0, 32'd0);
  endtask

  task automatic moves_roundtrip();
    logic [4:0]  dst [n_moves];
    logic [31:0] val;
    for (int i = 0; i < n_moves; i++) begin
      dst[i] = rand_reg();
      val    = $urandom();
      load_reg(dst[i], val);
    end
    // Later writes may hit the same register
    for (int i = 0; i < n_moves; i++) begin
      exec_check(op_fmv_x_w, rand_reg(), dst[i], 5'd0, 32'd0, shadow[dst[i]]);
    end
  endtask

  task automatic sign_injection();
    fp_op_e     op;
    logic [4:0] rs1;
    logic [4:0] rs2;
    for (int i = 0; i < n_sgnj; i++) begin
      op  = (i % 3 == 0) ? op_fsgnj : (i % 3 == 1) ? op_fsgnjn : op_fsgnjx;
      rs1 = rand_reg();
      rs2 = rand_reg();
      exec_check(op, rand_reg(), rs1, rs2, 32'd0, expect_sgnj(op, shadow[rs1], shadow[rs2]));
    end
  endtask

  task automatic min_max();
    logic [31:0] a_vals [n_mm];
    logic [31:0] b_vals [n_mm];
    // Ordinary, signed zeros, one NaN, two NaNs
    a_vals = '{32'h3f80_0000, 32'hc040_0000, 32'h0000_0000, 32'h8000_0000,
               32'h7fc0_0000, 32'h4049_0fdb, 32'h7f80_0001};
    b_vals = '{32'h4000_0000, 32'h3f00_0000, 32'h8000_0000, 32'h0000_0000,
               32'hbf80_0000, 32'h7f80_0001, 32'hffc0_0000};
    for (int i = 0; i < n_mm; i++) begin
      load_reg(5'd1, a_vals[i]);
      load_reg(5'd2, b_vals[i]);
      exec_check(op_fmin, 5'd3, 5'd1, 5'd2, 32'd0, expect_minmax(1'b0, a_vals[i], b_vals[i]));
      exec_check(op_fmax, 5'd4, 5'd1, 5'd2, 32'd0, expect_minmax(1'b1, a_vals[i], b_vals[i]));
    end
  endtask

  task automatic compares();
    logic [31:0] a_vals [n_cmp];
    logic [31:0] b_vals [n_cmp];
    // Equal, a<b, a>b, zero pair, NaN on either side
    a_vals = '{32'h3fc0_0000, 32'hbf80_0000, 32'h4080_0000,
               32'h8000_0000, 32'h7fc0_0000, 32'h3f80_0000};
    b_vals = '{32'h3fc0_0000, 32'h3f80_0000, 32'h4000_0000,
               32'h0000_0000, 32'h3f80_0000, 32'hff80_0001};
    for (int i = 0; i < n_cmp; i++) begin
      load_reg(5'd6, a_vals[i]);
      load_reg(5'd7, b_vals[i]);
      exec_check(op_feq, 5'd10, 5'd6, 5'd7, 32'd0, expect_cmp(op_feq, a_vals[i], b_vals[i]));
      exec_check(op_flt, 5'd10, 5'd6, 5'd7, 32'd0, expect_cmp(op_flt, a_vals[i], b_vals[i]));
      exec_check(op_fle, 5'd10, 5'd6, 5'd7, 32'd0, expect_cmp(op_fle, a_vals[i], b_vals[i]));
    end
  endtask

  task automatic classify();
    logic [31:0] vals [n_cls];
    // Listed in mask bit order from -inf up to quiet NaN
    vals = '{32'hff80_0000, 32'hbf80_0000, 32'h8000_0001, 32'h8000_0000, 32'h0000_0000,
             32'h0040_0000, 32'h3f80_0000, 32'h7f80_0000, 32'h7f80_0001, 32'h7fc0_0000};
    for (int i = 0; i < n_cls; i++) begin
      load_reg(5'd8, vals[i]);
      exec_check(op_fclass, 5'd11, 5'd8, 5'd0, 32'd0, 32'd1 << i);
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(11482));
    arst_n       = 1'b0;
    issue_req    = 1'b0;
    result_ack   = 1'b0;
    issue        = '0;
    next_id      = '0;
    cycle_count  = 0;
    ack_rises    = 0;
    req_rises    = 0;
    issue_ack_q  = 1'b0;
    result_req_q = 1'b0;
    ended        = 1'b0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (10) @(negedge uin_rvfpm);
    arst_n = 1'b1;

    reset_and_order();
    moves_roundtrip();
    sign_injection();
    min_max();
    compares();
    classify();

    ended = 1'b1;
    $display("** PASS **");
    $finish;
  end

  // Run cut short by a bound assertion
  final begin
    if (!ended) begin
      $display("Run stopped before the tests finished");
      $display("** FAIL **");
    end
  end

endmodule

`default_nettype wire

/* project.f */
fp_pkg.sv
xif_pkg.sv
fp_regfile.sv
fp_exec_unit.sv
exec_timer.sv
issue_ctrl.sv
rvfpm.sv
rvfpm_assert.sv
rvfpm_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rvfpm_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	elif grep -qF '** PASS **' $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
